// ==== design/drp_pkg.sv ====
// Shared DRP types and constants; the 16-word/9-bit sizes follow the channel port, timing assumes one clock
package drp_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Bus widths and sizes
  //////////////////////////////////////////////////////////////////////////

  localparam int DRP_ADDR_W = 9;
  localparam int DRP_DATA_W = 16;
  // Full attribute space reachable by the address
  localparam int DRP_DEPTH  = 1 << DRP_ADDR_W;

  // Register bank answers this many cycles after the enable
  localparam int DRP_LATENCY = 2;

  // Host hysteresis window reload and counter width
  localparam int HOLDOFF_COUNT = 15;
  localparam int HOLDOFF_W     = 4;

  // Monitor poll interval, power of two so the counter wraps cleanly
  localparam int POLL_PERIOD = 64;
  localparam int POLL_W      = $clog2(POLL_PERIOD);

  //////////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////////

  typedef logic [DRP_ADDR_W-1:0] drp_addr_t;
  typedef logic [DRP_DATA_W-1:0] drp_data_t;
  typedef logic [HOLDOFF_W-1:0]  holdoff_t;
  typedef logic [POLL_W-1:0]     poll_cnt_t;

  // Digital-monitor readout register
  localparam drp_addr_t DMON_ADDR = 9'h1F0;

  // One requester's pending access (26 bits)
  typedef struct packed {
    drp_addr_t addr;
    drp_data_t wdata;
    logic      we;
  } drp_req_t;

  // Result steered back to the transaction owner (17 bits)
  typedef struct packed {
    logic      rdy;
    drp_data_t rdata;
  } drp_rsp_t;

  typedef enum logic {IDLE, BUSY} arb_state_t;

  typedef enum logic [1:0] {WAIT_TRIG, REQ, WAIT_RDY} host_state_t;

endpackage

// ==== design/drp_host_port.sv ====
// Host DRP port; trigger_i may be asynchronous, one access per holdoff window while it stays high
`timescale 1ns/1ps

module drp_host_port import drp_pkg::*; (
  input  logic      FREEDRPCLK_i,
  input  logic      rx_wordclk,
  input  logic      trigger_i,
  input  drp_req_t  req_data_i,
  input  logic      gnt_i,
  input  drp_rsp_t  rsp_i,
  output logic      req_o,
  output drp_req_t  req_o_data_o,
  output drp_data_t drp_do_o,
  output logic      done_o
);

  logic [1:0]  trig_sync_q;
  logic        trig_s;
  logic        fire;
  holdoff_t    holdoff_q;
  host_state_t state_q;
  drp_req_t    req_q;
  drp_data_t   rdata_q;
  logic        done_q;

  ////////////////////////////////////////////////////////////////////////////
  // Trigger crossing
  ////////////////////////////////////////////////////////////////////////////

  // Two-flop synchronizer from the control domain
  always_ff @(posedge FREEDRPCLK_i or posedge rx_wordclk) begin
    if (rx_wordclk) begin
      trig_sync_q <= '0;
    end else begin
      trig_sync_q <= {trig_sync_q[0], trigger_i};
    end
  end

  assign trig_s = trig_sync_q[1];

  // Fire only when idle, trigger seen and the window has expired
  assign fire = (state_q == WAIT_TRIG) && trig_s && (holdoff_q == '0);

  ////////////////////////////////////////////////////////////////////////////
  // Hysteresis counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge FREEDRPCLK_i or posedge rx_wordclk) begin
    if (rx_wordclk) begin
      holdoff_q <= '0;
    end else if (!trig_s) begin
      // Trigger released, next rise fires at once
      holdoff_q <= '0;
    end else if (fire) begin
      holdoff_q <= holdoff_t'(HOLDOFF_COUNT);
    end else if (holdoff_q != '0) begin
      holdoff_q <= holdoff_q - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Access FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge FREEDRPCLK_i or posedge rx_wordclk) begin
    if (rx_wordclk) begin
      state_q <= WAIT_TRIG;
      done_q  <= 1'b0;
      rdata_q <= '0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        WAIT_TRIG: if (fire)  state_q <= REQ;
        // Request level held until the arbiter grants
        REQ:       if (gnt_i) state_q <= WAIT_RDY;
        WAIT_RDY: begin
          if (rsp_i.rdy) begin
            state_q <= WAIT_TRIG;
            done_q  <= 1'b1;
            rdata_q <= rsp_i.rdata;
          end
        end
        default:   state_q <= WAIT_TRIG;
      endcase
    end
  end

  // Access fields frozen at firing
  always_ff @(posedge FREEDRPCLK_i) begin
    if (fire) begin
      req_q <= req_data_i;
    end
  end

  assign req_o        = (state_q == REQ);
  assign req_o_data_o = req_q;
  assign drp_do_o     = rdata_q;
  assign done_o       = done_q;

endmodule

// ==== design/dmon_poller.sv ====
// Digital-monitor poller; read only, result is stale by up to one poll period plus bus wait
`timescale 1ns/1ps

module dmon_poller import drp_pkg::*; (
  input  logic      FREEDRPCLK_i,
  input  logic      rx_wordclk,
  input  logic      gnt_i,
  input  drp_rsp_t  rsp_i,
  output logic      req_o,
  output drp_req_t  req_data_o,
  output drp_data_t dmonitor_data_o
);

  poll_cnt_t period_q;
  logic      wrap;
  logic      req_q;
  drp_data_t dmon_q;

  // Free-running interval counter
  assign wrap = (period_q == poll_cnt_t'(POLL_PERIOD - 1));

  always_ff @(posedge FREEDRPCLK_i or posedge rx_wordclk) begin
    if (rx_wordclk) begin
      period_q <= '0;
    end else if (wrap) begin
      period_q <= '0;
    end else begin
      period_q <= period_q + 1'b1;
    end
  end

  // Request raised on wrap, dropped once granted
  // A wrap in the grant cycle wins, so no poll is skipped
  always_ff @(posedge FREEDRPCLK_i or posedge rx_wordclk) begin
    if (rx_wordclk) begin
      req_q <= 1'b0;
    end else if (wrap) begin
      req_q <= 1'b1;
    end else if (gnt_i) begin
      req_q <= 1'b0;
    end
  end

  // Hold the last monitor word; ready only reaches us for our own reads
  always_ff @(posedge FREEDRPCLK_i or posedge rx_wordclk) begin
    if (rx_wordclk) begin
      dmon_q <= '0;
    end else if (rsp_i.rdy) begin
      dmon_q <= rsp_i.rdata;
    end
  end

  assign req_o            = req_q;
  // Always a read of the monitor register
  assign req_data_o.addr  = DMON_ADDR;
  assign req_data_o.wdata = '0;
  assign req_data_o.we    = 1'b0;
  assign dmonitor_data_o  = dmon_q;

endmodule

// ==== design/drp_arbiter.sv ====
// Two-way round-robin DRP arbiter; one transaction in flight, requesters must hold requests until granted
`timescale 1ns/1ps

module drp_arbiter import drp_pkg::*; (
  input  logic      FREEDRPCLK_i,
  input  logic      rx_wordclk,
  input  logic      host_req_i,
  input  logic      poll_req_i,
  input  drp_req_t  host_req_data_i,
  input  drp_req_t  poll_req_data_i,
  output logic      host_gnt_o,
  output logic      poll_gnt_o,
  output drp_rsp_t  host_rsp_o,
  output drp_rsp_t  poll_rsp_o,
  output logic      drp_en_o,
  output logic      drp_we_o,
  output drp_addr_t drp_addr_o,
  output drp_data_t drp_di_o,
  input  logic      drp_rdy_i,
  input  drp_data_t drp_do_i
);

  arb_state_t state_q;
  logic       last_poll_q;
  logic       owner_poll_q;
  logic       pick_host;
  logic       pick_poll;
  logic       start;
  logic       en_q;
  logic       host_gnt_q;
  logic       poll_gnt_q;
  drp_req_t   bus_q;

  ////////////////////////////////////////////////////////////////////////////
  // Selection
  ////////////////////////////////////////////////////////////////////////////

  // On contention the side that did not win last goes first
  assign pick_host = host_req_i && (!poll_req_i || last_poll_q);
  assign pick_poll = poll_req_i && !pick_host;
  assign start     = (state_q == IDLE) && (host_req_i || poll_req_i);

  always_ff @(posedge FREEDRPCLK_i or posedge rx_wordclk) begin
    if (rx_wordclk) begin
      state_q      <= IDLE;
      // Pretend the poller won last so the host leads after reset
      last_poll_q  <= 1'b1;
      owner_poll_q <= 1'b0;
      en_q         <= 1'b0;
      host_gnt_q   <= 1'b0;
      poll_gnt_q   <= 1'b0;
    end else begin
      // Grant and enable are single-cycle pulses
      en_q       <= start;
      host_gnt_q <= start && pick_host;
      poll_gnt_q <= start && pick_poll;
      if (start) begin
        state_q      <= BUSY;
        last_poll_q  <= pick_poll;
        owner_poll_q <= pick_poll;
      end else if ((state_q == BUSY) && drp_rdy_i) begin
        state_q <= IDLE;
      end
    end
  end

  // Winner's fields driven onto the bus with the enable
  always_ff @(posedge FREEDRPCLK_i) begin
    if (start) begin
      bus_q <= pick_poll ? poll_req_data_i : host_req_data_i;
    end
  end

  assign drp_en_o   = en_q;
  assign drp_we_o   = bus_q.we;
  assign drp_addr_o = bus_q.addr;
  assign drp_di_o   = bus_q.wdata;
  assign host_gnt_o = host_gnt_q;
  assign poll_gnt_o = poll_gnt_q;

  ////////////////////////////////////////////////////////////////////////////
  // Response steering, owner only
  ////////////////////////////////////////////////////////////////////////////

  assign host_rsp_o.rdy   = drp_rdy_i && !owner_poll_q;
  assign host_rsp_o.rdata = owner_poll_q ? '0 : drp_do_i;
  assign poll_rsp_o.rdy   = drp_rdy_i && owner_poll_q;
  assign poll_rsp_o.rdata = owner_poll_q ? drp_do_i : '0;

endmodule

// ==== design/drp_reg_bank.sv ====
// Behavioral stand-in for the channel attributes; contents are not reset and start unknown
`timescale 1ns/1ps

module drp_reg_bank import drp_pkg::*; (
  input  logic      FREEDRPCLK_i,
  input  logic      rx_wordclk,
  input  logic      drp_en_i,
  input  logic      drp_we_i,
  input  drp_addr_t drp_addr_i,
  input  drp_data_t drp_di_i,
  output logic      drp_rdy_o,
  output drp_data_t drp_do_o
);

  drp_data_t                  mem [DRP_DEPTH];
  logic      [DRP_LATENCY-1:0] rdy_pipe_q;
  drp_data_t                  data_pipe_q [DRP_LATENCY];

  // Write and read both act on the enable cycle
  // A write therefore returns the previous contents
  always_ff @(posedge FREEDRPCLK_i) begin
    if (drp_en_i && drp_we_i) begin
      mem[drp_addr_i] <= drp_di_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Fixed-latency return path
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge FREEDRPCLK_i or posedge rx_wordclk) begin
    if (rx_wordclk) begin
      rdy_pipe_q <= '0;
    end else begin
      rdy_pipe_q <= {rdy_pipe_q[DRP_LATENCY-2:0], drp_en_i};
    end
  end

  always_ff @(posedge FREEDRPCLK_i) begin
    if (drp_en_i) begin
      data_pipe_q[0] <= mem[drp_addr_i];
    end
    // Later stages just follow the first
    for (int i = 1; i < DRP_LATENCY; i++) begin
      data_pipe_q[i] <= data_pipe_q[i-1];
    end
  end

  assign drp_rdy_o = rdy_pipe_q[DRP_LATENCY-1];
  assign drp_do_o  = data_pipe_q[DRP_LATENCY-1];

endmodule

// ==== design/drp_subsys_top.sv ====
// DRP subsystem top; single clock domain except drp_trigger_i, no transceiver IP inside
`timescale 1ns/1ps

module drp_subsys_top import drp_pkg::*; (
  input  logic      FREEDRPCLK_i,
  input  logic      rx_wordclk,
  input  logic      drp_trigger_i,
  input  drp_req_t  drp_req_i,
  output drp_data_t drp_do_o,
  output logic      drp_done_o,
  output drp_data_t dmonitor_data_o
);

  // Requester side
  logic      host_req;
  logic      poll_req;
  drp_req_t  host_req_data;
  drp_req_t  poll_req_data;
  logic      host_gnt;
  logic      poll_gnt;
  drp_rsp_t  host_rsp;
  drp_rsp_t  poll_rsp;

  // Bank side
  logic      drp_en;
  logic      drp_we;
  drp_addr_t drp_addr;
  drp_data_t drp_di;
  logic      drp_rdy;
  drp_data_t drp_do;

  ////////////////////////////////////////////////////////////////////////////
  // Requesters
  ////////////////////////////////////////////////////////////////////////////

  drp_host_port u_host_port (
    .FREEDRPCLK_i (FREEDRPCLK_i),
    .rx_wordclk   (rx_wordclk),
    .trigger_i    (drp_trigger_i),
    .req_data_i   (drp_req_i),
    .gnt_i        (host_gnt),
    .rsp_i        (host_rsp),
    .req_o        (host_req),
    .req_o_data_o (host_req_data),
    .drp_do_o     (drp_do_o),
    .done_o       (drp_done_o)
  );

  dmon_poller u_dmon_poller (
    .FREEDRPCLK_i    (FREEDRPCLK_i),
    .rx_wordclk      (rx_wordclk),
    .gnt_i           (poll_gnt),
    .rsp_i           (poll_rsp),
    .req_o           (poll_req),
    .req_data_o      (poll_req_data),
    .dmonitor_data_o (dmonitor_data_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Shared bus
  ////////////////////////////////////////////////////////////////////////////

  drp_arbiter u_arbiter (
    .FREEDRPCLK_i    (FREEDRPCLK_i),
    .rx_wordclk      (rx_wordclk),
    .host_req_i      (host_req),
    .poll_req_i      (poll_req),
    .host_req_data_i (host_req_data),
    .poll_req_data_i (poll_req_data),
    .host_gnt_o      (host_gnt),
    .poll_gnt_o      (poll_gnt),
    .host_rsp_o      (host_rsp),
    .poll_rsp_o      (poll_rsp),
    .drp_en_o        (drp_en),
    .drp_we_o        (drp_we),
    .drp_addr_o      (drp_addr),
    .drp_di_o        (drp_di),
    .drp_rdy_i       (drp_rdy),
    .drp_do_i        (drp_do)
  );

  drp_reg_bank u_reg_bank (
    .FREEDRPCLK_i (FREEDRPCLK_i),
    .rx_wordclk   (rx_wordclk),
    .drp_en_i     (drp_en),
    .drp_we_i     (drp_we),
    .drp_addr_i   (drp_addr),
    .drp_di_i     (drp_di),
    .drp_rdy_o    (drp_rdy),
    .drp_do_o     (drp_do)
  );

endmodule

// ==== bench/drp_subsys_sva.sv ====
// DRP bus protocol checks; the host latency bound assumes a rise from idle with at most one poll ahead
`timescale 1ns/1ps

module drp_subsys_sva import drp_pkg::*; (
  input logic FREEDRPCLK_i,
  input logic rx_wordclk,
  input logic drp_en_i,
  input logic drp_rdy_i,
  input logic host_gnt_i,
  input logic poll_gnt_i,
  input logic trigger_i,
  input logic done_i
);

  // Failure count, watched from the testbench
  int   fail_cnt = 0;
  logic outstanding_q;
  logic trig_d_q;
  logic timing_q;
  int   lat_q;

  ////////////////////////////////////////////////////////////////////////////
  // Reference state
  ////////////////////////////////////////////////////////////////////////////

  // One transaction in flight from enable until ready
  always_ff @(posedge FREEDRPCLK_i or posedge rx_wordclk) begin
    if (rx_wordclk) begin
      outstanding_q <= 1'b0;
    end else if (drp_en_i) begin
      outstanding_q <= 1'b1;
    end else if (drp_rdy_i) begin
      outstanding_q <= 1'b0;
    end
  end

  // Cycles from the first edge that sees the trigger high up to done
  always_ff @(posedge FREEDRPCLK_i or posedge rx_wordclk) begin
    if (rx_wordclk) begin
      trig_d_q <= 1'b0;
      timing_q <= 1'b0;
      lat_q    <= 0;
    end else begin
      trig_d_q <= trigger_i;
      if (trigger_i && !trig_d_q) begin
        timing_q <= 1'b1;
        lat_q    <= 0;
      end else if (timing_q && done_i) begin
        timing_q <= 1'b0;
      end else if (timing_q) begin
        lat_q <= lat_q + 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus protocol
  ////////////////////////////////////////////////////////////////////////////

  a_en_pulse: assert property (@(posedge FREEDRPCLK_i) disable iff (rx_wordclk)
    drp_en_i |=> !drp_en_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("DRP enable held longer than one cycle");
    end

  // Ready exactly DRP_LATENCY cycles after each enable, and never otherwise
  a_rdy_latency: assert property (@(posedge FREEDRPCLK_i) disable iff (rx_wordclk)
    drp_rdy_i == $past(drp_en_i, DRP_LATENCY))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("DRP ready not at the fixed latency after enable");
    end

  a_one_outstanding: assert property (@(posedge FREEDRPCLK_i) disable iff (rx_wordclk)
    drp_en_i |-> !outstanding_q)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("DRP enable while a transaction is outstanding");
    end

  a_gnt_exclusive: assert property (@(posedge FREEDRPCLK_i) disable iff (rx_wordclk)
    !(host_gnt_i && poll_gnt_i))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("Host and poll grants high together");
    end

  ////////////////////////////////////////////////////////////////////////////
  // Host latency
  ////////////////////////////////////////////////////////////////////////////

  // Sync, grant and done give the floor
  a_host_min: assert property (@(posedge FREEDRPCLK_i) disable iff (rx_wordclk)
    timing_q && done_i |-> lat_q >= 6)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("Host done too soon after trigger rise");
    end

  // One poll transaction ahead adds DRP_LATENCY plus the turnaround
  a_host_max: assert property (@(posedge FREEDRPCLK_i) disable iff (rx_wordclk)
    timing_q |-> lat_q <= 6 + DRP_LATENCY + 2)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("Host done missing or too late after trigger rise");
    end

endmodule

bind drp_subsys_top drp_subsys_sva u_sva (
  .FREEDRPCLK_i (FREEDRPCLK_i),
  .rx_wordclk   (rx_wordclk),
  .drp_en_i     (drp_en),
  .drp_rdy_i    (drp_rdy),
  .host_gnt_i   (host_gnt),
  .poll_gnt_i   (poll_gnt),
  .trigger_i    (drp_trigger_i),
  .done_i       (drp_done_o)
);

// ==== bench/tb_drp_subsys.sv ====
// DRP subsystem testbench; checks read-back, hysteresis and monitor, bound SVA covers the bus
`timescale 1ns/1ps

module tb_drp_subsys import drp_pkg::*; ();

  logic      freedrpclk;
  logic      rx_wordclk;
  logic      drp_trigger;
  drp_req_t  drp_req;
  drp_data_t drp_do;
  logic      drp_done;
  drp_data_t dmonitor_data;

  // Reference copy of every write
  drp_data_t shadow [DRP_DEPTH];
  bit        written [DRP_DEPTH];
  drp_addr_t written_q [$];

  drp_subsys_top DUT (
    .FREEDRPCLK_i    (freedrpclk),
    .rx_wordclk      (rx_wordclk),
    .drp_trigger_i   (drp_trigger),
    .drp_req_i       (drp_req),
    .drp_do_o        (drp_do),
    .drp_done_o      (drp_done),
    .dmonitor_data_o (dmonitor_data)
  );

  // 40 ns period
  always #20 freedrpclk = ~freedrpclk;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  // Bound checks raise this count
  always @(negedge freedrpclk) begin
    if (DUT.u_sva.fail_cnt != 0) begin
      abort_run("Protocol assertion failed on the DRP bus");
    end
  end

  task automatic record_write(input drp_addr_t addr, input drp_data_t data);
    shadow[addr] = data;
    if (!written[addr]) begin
      written[addr] = 1'b1;
      written_q.push_back(addr);
    end
  endtask

  task automatic check_read(input drp_addr_t addr, input drp_data_t got);
    assert (got == shadow[addr]) else begin
      abort_run($sformatf("CHECK FAILED drp_do_o addr %h expected %h actual %h",
                          addr, shadow[addr], got));
    end
  endtask

  // One trigger rise, one access; trigger dropped after done
  task automatic host_access(input drp_addr_t addr, input drp_data_t wdata,
                             input logic we, output drp_data_t rdata);
    drp_req_t req;
    int       waited;
    req.addr  = addr;
    req.wdata = wdata;
    req.we    = we;
    waited    = 0;
    @(posedge freedrpclk);
    drp_req     <= req;
    drp_trigger <= 1'b1;
    @(negedge freedrpclk);
    while (!drp_done) begin
      waited++;
      if (waited > POLL_PERIOD) begin
        abort_run("Timeout waiting for drp_done_o after trigger");
      end
      @(negedge freedrpclk);
    end
    rdata = drp_do;
    @(posedge freedrpclk);
    drp_trigger <= 1'b0;
    // Synchronizer sees the trigger low before the next rise
    repeat (4) @(posedge freedrpclk);
  endtask

  // First firing right after sync, then one per HOLDOFF_COUNT + 1 cycles
  function automatic int expected_firings(input int hold_cycles);
    return (hold_cycles - 1) / (HOLDOFF_COUNT + 1) + 1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Scenarios
  ////////////////////////////////////////////////////////////////////////////

  task automatic write_then_read(input int count);
    drp_addr_t addr;
    drp_data_t data;
    drp_data_t rd;
    for (int i = 0; i < count; i++) begin
      addr = drp_addr_t'($urandom());
      data = drp_data_t'($urandom());
      host_access(addr, data, 1'b1, rd);
      record_write(addr, data);
    end
    for (int i = 0; i < written_q.size(); i++) begin
      host_access(written_q[i], '0, 1'b0, rd);
      check_read(written_q[i], rd);
    end
  endtask

  // Held trigger, done pulses counted over a fixed window
  task automatic check_hysteresis(input int hold, input int settle);
    drp_req_t req;
    int       pulses;
    req.addr  = written_q[0];
    req.wdata = '0;
    req.we    = 1'b0;
    pulses    = 0;
    @(posedge freedrpclk);
    drp_req     <= req;
    drp_trigger <= 1'b1;
    for (int c = 0; c < hold; c++) begin
      @(negedge freedrpclk);
      if (drp_done) begin
        pulses++;
      end
    end
    @(posedge freedrpclk);
    drp_trigger <= 1'b0;
    for (int c = 0; c < settle; c++) begin
      @(negedge freedrpclk);
      if (drp_done) begin
        pulses++;
      end
    end
    assert (pulses == expected_firings(hold)) else begin
      abort_run($sformatf("CHECK FAILED drp_done_o pulses expected %h actual %h",
                          expected_firings(hold), pulses));
    end
    check_read(req.addr, drp_do);
  endtask

  task automatic check_monitor();
    drp_data_t val;
    drp_data_t rd;
    drp_addr_t addr;
    logic      seen;
    logic      stop;
    int        c;
    val = drp_data_t'($urandom());
    if (val == dmonitor_data) begin
      val = ~val;
    end
    host_access(DMON_ADDR, val, 1'b1, rd);
    record_write(DMON_ADDR, val);
    seen = 1'b0;
    stop = 1'b0;
    c    = 0;
    fork
      begin
        while (!seen && c < 2 * POLL_PERIOD) begin
          @(negedge freedrpclk);
          if (dmonitor_data == val) begin
            seen = 1'b1;
          end
          c++;
        end
        stop = 1'b1;
      end
      begin
        // Host reads keep the bus contended
        while (!stop) begin
          addr = written_q[$urandom() % written_q.size()];
          host_access(addr, '0, 1'b0, rd);
          check_read(addr, rd);
        end
      end
    join
    assert (seen) else begin
      abort_run($sformatf("CHECK FAILED dmonitor_data_o expected %h actual %h",
                          val, dmonitor_data));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    freedrpclk  = 1'b0;
    rx_wordclk  = 1'b1;
    drp_trigger = 1'b0;
    drp_req     = '0;
    void'($urandom(32'h221abe84));
    repeat (3) @(posedge freedrpclk);
    rx_wordclk <= 1'b0;
    @(negedge freedrpclk);
    assert (!drp_done && drp_do == '0 && dmonitor_data == '0) else begin
      abort_run("Outputs not idle or zero after reset");
    end
    write_then_read(16);
    check_hysteresis(40, 20);
    check_monitor();
    if (DUT.u_sva.fail_cnt != 0) begin
      abort_run("Protocol assertion failed on the DRP bus");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

// ==== files.f ====
design/drp_pkg.sv
design/drp_host_port.sv
design/dmon_poller.sv
design/drp_arbiter.sv
design/drp_reg_bank.sv
design/drp_subsys_top.sv
bench/drp_subsys_sva.sv
bench/tb_drp_subsys.sv

// ==== Makefile ====
TOP := tb_drp_subsys
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

obj_dir/V$(TOP): files.f $(wildcard design/*.sv bench/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f files.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir $(LOG)
